// File: Makefile
# Verilator build and run of the afu_core testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_afu_core
FILELIST  = afu_core.f
SIM       = obj_dir/V$(TOP)
SIMFLAGS  = +verilator+error+limit+1000
PASS_MSG  = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$($(SIM) $(SIMFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: afu_core.f
+incdir+.
smem_pkg.sv
line_buffer.sv
line_counter.sv
tx_port.sv
batch_fsm.sv
afu_core.sv
afu_core_assertions.sv
tb_afu_core.sv

// File: afu_core.sv
// ============================================================
// Batch controller top: polls the host, loads a batch of lines
// and writes them back, then signals completion
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module afu_core (
	input  logic                     CLK_400M,
	input  logic                     PresetEmpty,
	input  logic                     core_start,
	input  logic                     rd_almostfull,
	input  logic                     wr_almostfull,
	input  smem_pkg::rx_rsp_t        rx,
	input  logic [`SMEM_ADDR_W-1:0]  src_ptr,
	input  logic [`SMEM_ADDR_W-1:0]  dst_ptr,
	output smem_pkg::tx_rd_t         tx_rd,
	output smem_pkg::tx_wr_t         tx_wr
);

	smem_pkg::tx_op_e          op;
	logic                      clear;
	logic                      issue;
	logic                      write;
	logic [`SMEM_PTR_W-1:0]    line_idx;
	logic [`SMEM_PTR_W-1:0]    line_count;
	logic [`SMEM_PTR_W-1:0]    req_cnt;
	logic [`SMEM_PTR_W-1:0]    rcv_cnt;
	logic [`SMEM_PTR_W-1:0]    wr_cnt;
	logic                      all_requested;
	logic                      all_received;
	logic                      all_written;
	logic [`SMEM_LINE_W-1:0]   buf_rd_data;

	batch_fsm i_fsm (
		.CLK_400M      (CLK_400M),
		.PresetEmpty   (PresetEmpty),
		.core_start    (core_start),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.rx            (rx),
		.all_requested (all_requested),
		.all_received  (all_received),
		.all_written   (all_written),
		.req_cnt       (req_cnt),
		.wr_cnt        (wr_cnt),
		.op            (op),
		.clear         (clear),
		.issue         (issue),
		.write         (write),
		.line_idx      (line_idx),
		.line_count    (line_count)
	);

	line_counter i_cnt (
		.CLK_400M      (CLK_400M),
		.PresetEmpty   (PresetEmpty),
		.clear         (clear),
		.issue         (issue),
		.rx_valid      (rx.valid),
		.write         (write),
		.line_count    (line_count),
		.req_cnt       (req_cnt),
		.rcv_cnt       (rcv_cnt),
		.wr_cnt        (wr_cnt),
		.all_requested (all_requested),
		.all_received  (all_received),
		.all_written   (all_written)
	);

	// Responses land at the receive count
	line_buffer i_buf (
		.CLK_400M (CLK_400M),
		.wr_en    (rx.valid),
		.wr_idx   (rcv_cnt),
		.wr_data  (rx.data),
		.rd_idx   (line_idx),
		.rd_data  (buf_rd_data)
	);

	tx_port i_tx (
		.CLK_400M    (CLK_400M),
		.PresetEmpty (PresetEmpty),
		.op          (op),
		.line_idx    (line_idx),
		.line_data   (buf_rd_data),
		.src_ptr     (src_ptr),
		.dst_ptr     (dst_ptr),
		.tx_rd       (tx_rd),
		.tx_wr       (tx_wr)
	);

endmodule

// File: afu_core_assertions.sv
// ============================================================
// Protocol checks on the request channels, bound to afu_core
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module afu_core_assertions (
	input  logic                CLK_400M,
	input  logic                PresetEmpty,
	input  logic                core_start,
	input  logic                rd_almostfull,
	input  logic                wr_almostfull,
	input  smem_pkg::tx_rd_t    tx_rd,
	input  smem_pkg::tx_wr_t    tx_wr
);

	// Failed checks so far, read by the testbench
	int    fail_cnt = 0;
	logic  started;

	// Set by the first start pulse after reset
	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty)
			started <= 1'b0;
		else if (core_start)
			started <= 1'b1;
	end

	// ============================================================
	// Request rules
	// ============================================================
	quiet_before_start: assert property (@(posedge CLK_400M) disable iff (PresetEmpty)
		!started |-> !tx_rd.valid && !tx_wr.valid && !tx_wr.fence)
	else begin
		$error("request raised before any start pulse");
		fail_cnt++;
	end

	// A read follows a cycle with read space
	rd_after_space: assert property (@(posedge CLK_400M) disable iff (PresetEmpty)
		tx_rd.valid |-> !$past(rd_almostfull))
	else begin
		$error("read request after rd_almostfull was high");
		fail_cnt++;
	end

	wr_after_space: assert property (@(posedge CLK_400M) disable iff (PresetEmpty)
		tx_wr.valid |-> !$past(wr_almostfull))
	else begin
		$error("write request after wr_almostfull was high");
		fail_cnt++;
	end

endmodule

bind afu_core afu_core_assertions i_assert (
	.CLK_400M      (CLK_400M),
	.PresetEmpty   (PresetEmpty),
	.core_start    (core_start),
	.rd_almostfull (rd_almostfull),
	.wr_almostfull (wr_almostfull),
	.tx_rd         (tx_rd),
	.tx_wr         (tx_wr)
);

// File: batch_fsm.sv
// ============================================================
// Batch sequencer: poll, load, write-back, fence and completion
// Emits one opcode per cycle for the transmit stage
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module batch_fsm (
	input  logic                     CLK_400M,
	input  logic                     PresetEmpty,
	input  logic                     core_start,
	input  logic                     rd_almostfull,
	input  logic                     wr_almostfull,
	input  smem_pkg::rx_rsp_t        rx,
	input  logic                     all_requested,
	input  logic                     all_received,
	input  logic                     all_written,
	input  logic [`SMEM_PTR_W-1:0]   req_cnt,
	input  logic [`SMEM_PTR_W-1:0]   wr_cnt,
	output smem_pkg::tx_op_e         op,
	output logic                     clear,
	output logic                     issue,
	output logic                     write,
	output logic [`SMEM_PTR_W-1:0]   line_idx,
	output logic [`SMEM_PTR_W-1:0]   line_count
);

	smem_pkg::core_state_e        state;
	smem_pkg::core_state_e        state_nxt;
	logic                         exp_tag;
	logic [`SMEM_BATCH_W-1:0]     batch_size;
	logic                         tag_hit;
	logic                         accept;

	// Tag bit selected by the polarity expected for this batch
	assign tag_hit = exp_tag ? rx.data[`SMEM_TAG1_BIT] : rx.data[`SMEM_TAG0_BIT];
	assign accept  = (state == smem_pkg::st_check) && rx.valid && tag_hit;

	// Four lines per read
	assign line_count = {batch_size, 2'b00};

	// Load uses the request count, write-back the written count
	assign line_idx = (state == smem_pkg::st_out_read || state == smem_pkg::st_out_write)
	                ? wr_cnt : req_cnt;

	// ============================================================
	// State, polarity and batch size
	// ============================================================
	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			state      <= smem_pkg::st_idle;
			exp_tag    <= 1'b0;
			batch_size <= '0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				batch_size <= rx.data[`SMEM_BATCH_LSB +: `SMEM_BATCH_W];
				exp_tag    <= ~exp_tag;
			end
		end
	end

	// ============================================================
	// Next state and opcode
	// ============================================================
	always_comb begin
		state_nxt = state;
		op        = smem_pkg::op_none;
		clear     = 1'b0;
		issue     = 1'b0;
		write     = 1'b0;
		case (state)
			smem_pkg::st_idle: begin
				clear = 1'b1;
				if (core_start)
					state_nxt = smem_pkg::st_poll;
			end
			smem_pkg::st_poll: begin
				clear = 1'b1;
				if (!rd_almostfull) begin
					op        = smem_pkg::op_poll_rd;
					state_nxt = smem_pkg::st_check;
				end
			end
			smem_pkg::st_check: begin
				// Counters stay at zero until the batch is taken;
				// a handshake response lands in slot 0, later overwritten
				clear = 1'b1;
				if (rx.valid)
					state_nxt = tag_hit ? smem_pkg::st_load : smem_pkg::st_poll;
			end
			smem_pkg::st_load: begin
				if (!all_requested && !rd_almostfull) begin
					op    = smem_pkg::op_load_rd;
					issue = 1'b1;
				end
				if (all_requested && all_received)
					state_nxt = smem_pkg::st_out_read;
			end
			smem_pkg::st_out_read: begin
				// Buffer read of wr_cnt is in flight here
				state_nxt = all_written ? smem_pkg::st_fence : smem_pkg::st_out_write;
			end
			smem_pkg::st_out_write: begin
				if (!wr_almostfull) begin
					op        = smem_pkg::op_data_wr;
					write     = 1'b1;
					state_nxt = smem_pkg::st_out_read;
				end
			end
			smem_pkg::st_fence: begin
				if (!wr_almostfull) begin
					op        = smem_pkg::op_fence;
					state_nxt = smem_pkg::st_final;
				end
			end
			smem_pkg::st_final: begin
				if (!wr_almostfull) begin
					op        = smem_pkg::op_done_wr;
					state_nxt = smem_pkg::st_fence2;
				end
			end
			smem_pkg::st_fence2: begin
				if (!wr_almostfull) begin
					op        = smem_pkg::op_fence2;
					state_nxt = smem_pkg::st_idle;
				end
			end
			default: begin
				state_nxt = smem_pkg::st_idle;
			end
		endcase
	end

endmodule

// File: line_buffer.sv
// ============================================================
// Single-port line store for one batch, one-cycle read latency
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module line_buffer (
	input  logic                     CLK_400M,
	input  logic                     wr_en,
	input  logic [`SMEM_PTR_W-1:0]   wr_idx,
	input  logic [`SMEM_LINE_W-1:0]  wr_data,
	input  logic [`SMEM_PTR_W-1:0]   rd_idx,
	output logic [`SMEM_LINE_W-1:0]  rd_data
);

	localparam int IDX_W = $clog2(`SMEM_BUF_DEPTH);

	logic [`SMEM_LINE_W-1:0]  mem [`SMEM_BUF_DEPTH];

	// Index wraps at the buffer depth
	always_ff @(posedge CLK_400M) begin
		if (wr_en)
			mem[wr_idx[IDX_W-1:0]] <= wr_data;
		rd_data <= mem[rd_idx[IDX_W-1:0]];
	end

endmodule

// File: line_counter.sv
// ============================================================
// Request, receive and write counters of one batch
// with their compares against the batch line count
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module line_counter (
	input  logic                     CLK_400M,
	input  logic                     PresetEmpty,
	input  logic                     clear,
	input  logic                     issue,
	input  logic                     rx_valid,
	input  logic                     write,
	input  logic [`SMEM_PTR_W-1:0]   line_count,
	output logic [`SMEM_PTR_W-1:0]   req_cnt,
	output logic [`SMEM_PTR_W-1:0]   rcv_cnt,
	output logic [`SMEM_PTR_W-1:0]   wr_cnt,
	output logic                     all_requested,
	output logic                     all_received,
	output logic                     all_written
);

	// Index 0 requested, 1 received, 2 written
	logic [2:0][`SMEM_PTR_W-1:0]  cnt;
	logic [2:0]                   step;

	assign step = {write, rx_valid, issue};

	// Clear wins over any step in the same cycle
	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (step[i])
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	assign req_cnt = cnt[0];
	assign rcv_cnt = cnt[1];
	assign wr_cnt  = cnt[2];

	assign all_requested = (cnt[0] == line_count);
	assign all_received  = (cnt[1] == line_count);
	assign all_written   = (cnt[2] == line_count);

endmodule

// File: smem_defs.svh
// ============================================================
// Widths, region offsets and handshake fields for the core
// Included by the package and by every RTL file that needs them
// ============================================================
`ifndef SMEM_DEFS_SVH
`define SMEM_DEFS_SVH

// Line and address sizes
`define SMEM_LINE_W         512
`define SMEM_ADDR_W         58
`define SMEM_BATCH_W        10
`define SMEM_PTR_W          12
`define SMEM_BUF_DEPTH      512

// Input region, counted in lines from the source pointer
// Handshake line sits one line below it
`define SMEM_INPUT_OFFSET   (50331648 + 16384)

// Handshake line fields
`define SMEM_TAG0_BIT       480
`define SMEM_TAG1_BIT       482
`define SMEM_BATCH_LSB      448

// Completion word, code in the top bits
`define SMEM_DONE_CODE      16
`define SMEM_DONE_W         32

`endif

// File: smem_pkg.sv
// ============================================================
// Shared types of the batch controller: states, opcodes, ports
// ============================================================
`include "smem_defs.svh"

package smem_pkg;

	// Controller states
	typedef enum logic [3:0] {
		st_idle      = 4'd0,
		st_poll      = 4'd1,
		st_check     = 4'd2,
		st_load      = 4'd3,
		st_out_read  = 4'd4,
		st_out_write = 4'd5,
		st_fence     = 4'd6,
		st_final     = 4'd7,
		st_fence2    = 4'd8
	} core_state_e;

	// Transmit opcodes, one per request kind
	typedef enum logic [2:0] {
		op_none    = 3'd0,
		op_poll_rd = 3'd1,
		op_load_rd = 3'd2,
		op_data_wr = 3'd3,
		op_fence   = 3'd4,
		op_done_wr = 3'd5,
		op_fence2  = 3'd6
	} tx_op_e;

	// Read request channel
	typedef struct packed {
		logic                     valid;
		logic [`SMEM_ADDR_W-1:0]  addr;
	} tx_rd_t;

	// Write request channel, fence rides on valid
	typedef struct packed {
		logic                     valid;
		logic                     fence;
		logic [`SMEM_ADDR_W-1:0]  addr;
		logic [`SMEM_LINE_W-1:0]  data;
	} tx_wr_t;

	// Read response channel
	typedef struct packed {
		logic                     valid;
		logic [`SMEM_LINE_W-1:0]  data;
	} rx_rsp_t;

endpackage

// File: tb_afu_core.sv
// ============================================================
// Testbench for afu_core: host memory model, batch stimulus
// and data checks on every request the core sends
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module tb_afu_core;

	localparam int LW         = `SMEM_LINE_W;
	localparam int AW         = `SMEM_ADDR_W;
	localparam int WAIT_LIMIT = 2000;
	localparam logic [LW-1:0] DONE_WORD = {32'(`SMEM_DONE_CODE), {(LW-32){1'b0}}};

	logic               CLK_400M;
	logic               PresetEmpty;
	logic               core_start;
	logic               rd_almostfull;
	logic               wr_almostfull;
	smem_pkg::rx_rsp_t  rx;
	logic [AW-1:0]      src_ptr;
	logic [AW-1:0]      dst_ptr;
	smem_pkg::tx_rd_t   tx_rd;
	smem_pkg::tx_wr_t   tx_wr;

	logic [AW-1:0]      in_base;
	logic [AW-1:0]      hand_addr;
	integer             seed = 6;
	int                 cycle = 0;
	int                 errors = 0;
	int                 tests_run = 0;
	int                 tests_failed = 0;
	int                 test_base = 0;

	// Host model state, per batch unless noted
	logic [LW-1:0]      hs_script[$];
	logic [LW-1:0]      in_lines[$];
	logic [LW-1:0]      rsp_data[$];
	int                 rsp_due[$];
	int                 hs_n, in_n, wr_n, end_step;
	int                 exp_polls, exp_lines;
	int                 req_total = 0;
	int                 batches_done = 0;

	afu_core i_dut (
		.CLK_400M      (CLK_400M),
		.PresetEmpty   (PresetEmpty),
		.core_start    (core_start),
		.rd_almostfull (rd_almostfull),
		.wr_almostfull (wr_almostfull),
		.rx            (rx),
		.src_ptr       (src_ptr),
		.dst_ptr       (dst_ptr),
		.tx_rd         (tx_rd),
		.tx_wr         (tx_wr)
	);

	assign in_base   = src_ptr + AW'(`SMEM_INPUT_OFFSET);
	assign hand_addr = in_base - AW'(1);

	initial CLK_400M = 1'b0;
	always #4 CLK_400M = ~CLK_400M;

	task automatic check_eq(input string name, input logic [LW-1:0] got,
	                        input logic [LW-1:0] exp);
		assert (got === exp) else begin
			$display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("at %0t: %s", $time, msg);
		errors++;
	endtask

	function automatic logic [LW-1:0] hs_line(input logic tag0, input logic tag1,
	                                          input int batch);
		logic [LW-1:0] line;
		line = '0;
		line[`SMEM_TAG0_BIT] = tag0;
		line[`SMEM_TAG1_BIT] = tag1;
		line[`SMEM_BATCH_LSB +: `SMEM_BATCH_W] = batch[`SMEM_BATCH_W-1:0];
		return line;
	endfunction

	// ============================================================
	// Host side: almost-full noise and in-order read responses
	// ============================================================
	always begin : host_drive
		@(posedge CLK_400M);
		cycle++;
		#1;
		rd_almostfull = ({$random(seed)} % 4) == 0;
		wr_almostfull = ({$random(seed)} % 4) == 0;
		if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
			rx.valid = 1'b1;
			rx.data  = rsp_data.pop_front();
			void'(rsp_due.pop_front());
		end else begin
			rx = '0;
		end
	end

	// Requests are sampled mid-cycle, away from the edge
	always @(negedge CLK_400M) begin : monitor
		logic [LW-1:0] line;
		int d;
		if (!PresetEmpty && tx_rd.valid) begin
			req_total++;
			if (tx_rd.addr == hand_addr) begin
				hs_n++;
				line = (hs_script.size() > 0) ? hs_script.pop_front() : '0;
			end else begin
				check_eq("tx_rd.addr", LW'(tx_rd.addr), LW'(in_base + AW'(in_n)));
				check_eq("handshake reads before load", LW'(hs_n), LW'(exp_polls));
				for (int k = 0; k < LW / 32; k++)
					line[k*32 +: 32] = $random(seed);
				in_lines.push_back(line);
				in_n++;
			end
			d = cycle + 3 + ({$random(seed)} % 4);
			if (rsp_due.size() > 0 && d <= rsp_due[rsp_due.size()-1])
				d = rsp_due[rsp_due.size()-1] + 1;
			rsp_due.push_back(d);
			rsp_data.push_back(line);
		end
		if (!PresetEmpty && tx_wr.valid) begin
			req_total++;
			if (tx_wr.fence) begin
				if (end_step == 0 && wr_n == exp_lines) begin
					end_step = 1;
				end else if (end_step == 2) begin
					end_step = 3;
					batches_done++;
				end else begin
					note_failure("fence out of order");
				end
			end else if (tx_wr.addr == hand_addr) begin
				if (end_step != 1)
					note_failure("completion write not preceded by a fence");
				check_eq("tx_wr.data", tx_wr.data, DONE_WORD);
				end_step = 2;
			end else begin
				if (end_step != 0)
					note_failure("data write after the fence");
				check_eq("tx_wr.addr", LW'(tx_wr.addr), LW'(dst_ptr + AW'(wr_n)));
				if (wr_n < in_lines.size())
					check_eq("tx_wr.data", tx_wr.data, in_lines[wr_n]);
				else
					note_failure("data write beyond the loaded lines");
				wr_n++;
			end
		end
	end

	// ============================================================
	// Test sequencing
	// ============================================================
	function automatic int failures();
		return errors + i_dut.i_assert.fail_cnt;
	endfunction

	function automatic int count_of(input int which);
		case (which)
			0:       return hs_n;
			1:       return in_n;
			2:       return wr_n;
			default: return batches_done;
		endcase
	endfunction

	task automatic end_test(input int num, input string name);
		tests_run++;
		if (failures() != test_base)
			tests_failed++;
		$display("test %0d %s: %s", num, name, (failures() == test_base) ? "ok" : "fail");
		test_base = failures();
	endtask

	task automatic wait_for(input int which, input int target, input string what,
	                        output bit ok);
		int t;
		t = 0;
		while (count_of(which) < target && t < WAIT_LIMIT) begin
			@(posedge CLK_400M);
			t++;
		end
		ok = count_of(which) >= target;
		if (!ok)
			note_failure($sformatf("timeout waiting for %s", what));
	endtask

	task automatic new_batch(input int polls, input int lines);
		hs_n = 0;
		in_n = 0;
		wr_n = 0;
		end_step = 0;
		in_lines.delete();
		exp_polls = polls;
		exp_lines = lines;
	endtask

	task automatic pulse_start();
		@(posedge CLK_400M);
		#1 core_start = 1'b1;
		@(posedge CLK_400M);
		#1 core_start = 1'b0;
	endtask

	task automatic run_tests();
		bit ok;
		repeat (10) @(posedge CLK_400M);
		check_eq("requests before start", LW'(req_total), '0);
		end_test(1, "quiet after reset");

		// First batch: one refused poll, then tag 0 with two reads
		new_batch(2, 8);
		hs_script.push_back(hs_line(1'b0, 1'b0, 2));
		hs_script.push_back(hs_line(1'b1, 1'b0, 2));
		pulse_start();
		wait_for(0, 2, "second handshake read", ok);
		check_eq("input reads after refused poll", LW'(in_n), '0);
		end_test(2, "refused poll");
		if (!ok)
			return;
		wait_for(1, exp_lines, "input reads", ok);
		end_test(3, "input reads");
		if (!ok)
			return;
		wait_for(2, exp_lines, "data writes", ok);
		end_test(4, "write-back");
		if (!ok)
			return;
		wait_for(3, 1, "end of first batch", ok);
		check_eq("input read count", LW'(in_n), LW'(exp_lines));
		end_test(5, "fence and completion");
		if (!ok)
			return;

		// Second batch expects tag 1, so tag 0 alone is refused
		new_batch(2, 4);
		hs_script.push_back(hs_line(1'b1, 1'b0, 1));
		hs_script.push_back(hs_line(1'b0, 1'b1, 1));
		pulse_start();
		wait_for(3, 2, "end of second batch", ok);
		check_eq("handshake reads", LW'(hs_n), LW'(2));
		check_eq("input read count", LW'(in_n), LW'(4));
		check_eq("data write count", LW'(wr_n), LW'(4));
		end_test(6, "second batch on tag 1");
	endtask

	task automatic finish_run();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, failures());
		if (failures() == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	initial begin : main
		PresetEmpty   = 1'b1;
		core_start    = 1'b0;
		rd_almostfull = 1'b0;
		wr_almostfull = 1'b0;
		rx            = '0;
		src_ptr       = 58'h0000_0012_3400;
		dst_ptr       = 58'h0000_0380_0000;
		new_batch(0, 0);
		repeat (2) @(posedge CLK_400M);
		#1 PresetEmpty = 1'b0;
		run_tests();
		finish_run();
	end

endmodule

// File: tx_port.sv
// ============================================================
// Transmit stage: turns the opcode into registered read and
// write requests, forms addresses and the completion word
// ============================================================
`timescale 1ns/1ns
`include "smem_defs.svh"

module tx_port (
	input  logic                     CLK_400M,
	input  logic                     PresetEmpty,
	input  smem_pkg::tx_op_e         op,
	input  logic [`SMEM_PTR_W-1:0]   line_idx,
	input  logic [`SMEM_LINE_W-1:0]  line_data,
	input  logic [`SMEM_ADDR_W-1:0]  src_ptr,
	input  logic [`SMEM_ADDR_W-1:0]  dst_ptr,
	output smem_pkg::tx_rd_t         tx_rd,
	output smem_pkg::tx_wr_t         tx_wr
);

	localparam int AW = `SMEM_ADDR_W;
	localparam int LW = `SMEM_LINE_W;
	localparam int DW = `SMEM_DONE_W;

	logic [AW-1:0]  input_base;
	logic [AW-1:0]  hand_addr;
	logic [AW-1:0]  in_addr;
	logic [AW-1:0]  out_addr;
	logic [LW-1:0]  done_word;

	logic           rd_valid;
	logic [AW-1:0]  rd_addr;
	logic           wr_valid;
	logic           wr_fence;
	logic [AW-1:0]  wr_addr;
	logic [LW-1:0]  wr_data;

	// Address map
	assign input_base = src_ptr + AW'(`SMEM_INPUT_OFFSET);
	assign hand_addr  = input_base - AW'(1);
	assign in_addr    = input_base + AW'(line_idx);
	assign out_addr   = dst_ptr + AW'(line_idx);

	// Completion code on top, zeros below
	assign done_word = {DW'(`SMEM_DONE_CODE), {(LW-DW){1'b0}}};

	// ============================================================
	// Valids, one cycle per request
	// ============================================================
	always_ff @(posedge CLK_400M or posedge PresetEmpty) begin
		if (PresetEmpty) begin
			rd_valid <= 1'b0;
			wr_valid <= 1'b0;
			wr_fence <= 1'b0;
		end else begin
			rd_valid <= op inside {smem_pkg::op_poll_rd, smem_pkg::op_load_rd};
			wr_valid <= op inside {smem_pkg::op_data_wr, smem_pkg::op_fence,
			                       smem_pkg::op_done_wr, smem_pkg::op_fence2};
			wr_fence <= op inside {smem_pkg::op_fence, smem_pkg::op_fence2};
		end
	end

	// Address and data, held between requests
	always_ff @(posedge CLK_400M) begin
		case (op)
			smem_pkg::op_poll_rd: rd_addr <= hand_addr;
			smem_pkg::op_load_rd: rd_addr <= in_addr;
			smem_pkg::op_data_wr: begin
				wr_addr <= out_addr;
				wr_data <= line_data;
			end
			smem_pkg::op_done_wr: begin
				wr_addr <= hand_addr;
				wr_data <= done_word;
			end
			smem_pkg::op_fence, smem_pkg::op_fence2: begin
				wr_addr <= hand_addr;
				wr_data <= '0;
			end
			default: begin
			end
		endcase
	end

	assign tx_rd = '{valid: rd_valid, addr: rd_addr};
	assign tx_wr = '{valid: wr_valid, fence: wr_fence, addr: wr_addr, data: wr_data};

endmodule
